// ==== logic/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // meaningful widths
    typedef logic [9:0]  coord_t;
    typedef logic [12:0] rom_addr_t;
    typedef logic [15:0] ram_addr_t;
    typedef logic [15:0] pix565_t;
    typedef logic [7:0]  chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // raster position plus flags decoded for it
    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   hsync;
        logic   vsync;
        logic   active;
    } raster_t;

    // top-left corner
    typedef struct packed {
        coord_t x;
        coord_t y;
    } sprite_pos_t;

    typedef struct packed {
        sprite_pos_t player;
        sprite_pos_t obstacle;
    } scene_pos_t;

    typedef struct packed {
        rgb_t color;
        logic opaque;
    } sprite_pix_t;

    typedef enum logic [1:0] {
        idle,
        issue,
        capture
    } fetch_state_t;

    // 640x480 raster, counts in pixels and lines
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    localparam int SPRITE_SIZE = 32;

    // sprite slots in the rom
    localparam rom_addr_t PLAYER_BASE   = 13'd0;
    localparam rom_addr_t OBSTACLE_BASE = 13'd4096;

    // first of the four position words in ram
    localparam ram_addr_t POS_BASE = 16'h0100;

    localparam pix565_t KEY_COLOR = 16'hF81F;
    localparam rgb_t    BG_COLOR  = '{r: 8'h88, g: 8'hCC, b: 8'h88};

    // fixed sprite image, 4x4 checker with keyed 2x2 corners
    function automatic pix565_t sprite_word(rom_addr_t addr);
        logic [4:0] col;
        logic [4:0] row;
        logic       corner;
        logic       tile;
        col    = addr[4:0];
        row    = addr[9:5];
        corner = ((row < 5'd2) || (row > 5'd29)) && ((col < 5'd2) || (col > 5'd29));
        tile   = row[2] ^ col[2];
        if (corner) begin
            return KEY_COLOR;
        end
        // bit 12 picks the obstacle slot
        if (addr[12]) begin
            return tile ? 16'h07E0 : 16'h8410;
        end
        return tile ? 16'hFFE0 : 16'h001F;
    endfunction

endpackage

`default_nettype wire

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing import vga_pkg::*; (
    input  wire     sys_clk,
    input  wire     reset,
    output logic    pix_en,
    output raster_t raster,
    output logic    vblank_start
);

    coord_t h_nxt;
    coord_t v_nxt;
    logic   hsync_nxt;
    logic   vsync_nxt;
    logic   active_nxt;

    // divide by two, first clock after reset is a pixel
    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            pix_en <= 1'b1;
        end else begin
            pix_en <= ~pix_en;
        end
    end

    // next column and line with wrap
    always_comb begin
        h_nxt = raster.h + 1'b1;
        v_nxt = raster.v;
        if (raster.h == coord_t'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (raster.v == coord_t'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = raster.v + 1'b1;
            end
        end
    end

    // flags decoded for the next position so they register with it
    always_comb begin
        hsync_nxt  = !((h_nxt >= coord_t'(H_ACTIVE + H_FRONT)) &&
                       (h_nxt <  coord_t'(H_ACTIVE + H_FRONT + H_SYNC)));
        vsync_nxt  = !((v_nxt >= coord_t'(V_ACTIVE + V_FRONT)) &&
                       (v_nxt <  coord_t'(V_ACTIVE + V_FRONT + V_SYNC)));
        active_nxt = (h_nxt < coord_t'(H_ACTIVE)) && (v_nxt < coord_t'(V_ACTIVE));
    end

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            // top-left pixel, inside the active area
            raster <= '{h: '0, v: '0, hsync: 1'b1, vsync: 1'b1, active: 1'b1};
        end else if (pix_en) begin
            raster.h      <= h_nxt;
            raster.v      <= v_nxt;
            raster.hsync  <= hsync_nxt;
            raster.vsync  <= vsync_nxt;
            raster.active <= active_nxt;
        end
    end

    // raster sits at (0,480) for two clocks, only the strobe one counts
    assign vblank_start = pix_en && (raster.h == '0) && (raster.v == coord_t'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== logic/position_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module position_fetch import vga_pkg::*; (
    input  wire                        sys_clk,
    input  wire                        reset,
    input  wire                        vblank_start,
    input  wire [$bits(pix565_t)-1:0]  ram_q,
    output ram_addr_t                  ram_addr,
    output scene_pos_t                 scene
);

    fetch_state_t state;
    logic [1:0]   idx;
    scene_pos_t   shadow;
    scene_pos_t   scene_nxt;
    coord_t       word;

    // only the low bits hold a coordinate
    assign word = coord_t'(ram_q[9:0]);

    // last word joins the shadow copy on its way to scene
    always_comb begin
        scene_nxt            = shadow;
        scene_nxt.obstacle.y = word;
    end

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            state    <= idle;
            idx      <= 2'd0;
            ram_addr <= POS_BASE;
            scene    <= '0;
        end else begin
            case (state)
                idle: begin
                    if (vblank_start) begin
                        state    <= issue;
                        idx      <= 2'd0;
                        ram_addr <= POS_BASE;
                    end
                end
                issue: begin
                    // address on the bus, data one clock later
                    state <= capture;
                end
                capture: begin
                    if (idx == 2'd3) begin
                        // publish all four together, no tearing
                        state    <= idle;
                        ram_addr <= POS_BASE;
                        scene    <= scene_nxt;
                    end else begin
                        state    <= issue;
                        idx      <= idx + 2'd1;
                        ram_addr <= ram_addr + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                    idx   <= 2'd0;
                end
            endcase
        end
    end

    // shadow copy, words 0..2
    always_ff @(posedge sys_clk) begin
        if (state == capture) begin
            case (idx)
                2'd0:    shadow.player.x   <= word;
                2'd1:    shadow.player.y   <= word;
                2'd2:    shadow.obstacle.x <= word;
                default: shadow.obstacle.y <= word;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/sprite_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_rom import vga_pkg::*; (
    input  wire            sys_clk,
    input  wire            pix_en,
    input  wire rom_addr_t addr_a,
    input  wire rom_addr_t addr_b,
    output pix565_t        q_a,
    output pix565_t        q_b
);

    localparam int DEPTH = 2 ** $bits(rom_addr_t);

    pix565_t mem [0:DEPTH-1];

    // image computed from the address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = sprite_word(rom_addr_t'(i));
        end
    end

    // port a serves the player, port b the obstacle
    always_ff @(posedge sys_clk) begin
        if (pix_en) begin
            q_a <= mem[addr_a];
            q_b <= mem[addr_b];
        end
    end

endmodule

`default_nettype wire

// ==== logic/sprite_draw.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_draw import vga_pkg::*; #(
    parameter rom_addr_t BASE = PLAYER_BASE
) (
    input  wire              sys_clk,
    input  wire              reset,
    input  wire              pix_en,
    input  wire raster_t     raster,
    input  wire sprite_pos_t pos,
    output rom_addr_t        rom_addr,
    input  wire pix565_t     rom_q,
    output sprite_pix_t      pix,
    output raster_t          raster_out
);

    // idle raster, syncs high and blanked
    localparam raster_t RASTER_IDLE = '{h: '0, v: '0, hsync: 1'b1, vsync: 1'b1, active: 1'b0};

    coord_t    dx;
    coord_t    dy;
    logic      hit;
    rom_addr_t offset;

    logic    hit_d1;
    logic    hit_d2;
    raster_t raster_d1;
    raster_t raster_d2;

    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;

    // offsets wrap when left of or above the box, so check the lower bound too
    assign dx = raster.h - pos.x;
    assign dy = raster.v - pos.y;

    assign hit = (raster.h >= pos.x) && (dx < coord_t'(SPRITE_SIZE)) &&
                 (raster.v >= pos.y) && (dy < coord_t'(SPRITE_SIZE));

    // row*32 + column
    assign offset = {3'b000, dy[4:0], dx[4:0]};

    // stage 1, address and hit
    always_ff @(posedge sys_clk) begin
        if (pix_en) begin
            rom_addr <= BASE + offset;
        end
    end

    // hit and raster follow the rom read
    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            hit_d1    <= 1'b0;
            hit_d2    <= 1'b0;
            raster_d1 <= RASTER_IDLE;
            raster_d2 <= RASTER_IDLE;
        end else if (pix_en) begin
            hit_d1    <= hit;
            hit_d2    <= hit_d1;
            raster_d1 <= raster;
            raster_d2 <= raster_d1;
        end
    end

    // stage 2, rom data is out of the rom register
    assign r5 = rom_q[15:11];
    assign g6 = rom_q[10:5];
    assign b5 = rom_q[4:0];

    // expand 565 by repeating the top bits
    always_comb begin
        pix.color.r = {r5, r5[4:2]};
        pix.color.g = {g6, g6[5:4]};
        pix.color.b = {b5, b5[4:2]};
        // keyed words let whatever is below show through
        pix.opaque  = hit_d2 && raster_d2.active && (rom_q != KEY_COLOR);
    end

    assign raster_out = raster_d2;

endmodule

`default_nettype wire

// ==== logic/pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer import vga_pkg::*; (
    input  wire              sys_clk,
    input  wire              reset,
    input  wire              pix_en,
    input  wire raster_t     raster,
    input  wire sprite_pix_t player,
    input  wire sprite_pix_t obstacle,
    output rgb_t             rgb,
    output logic             hsync,
    output logic             vsync,
    output logic             blank_n
);

    rgb_t mix;

    // player over obstacle over background, black in blanking
    always_comb begin
        if (!raster.active) begin
            mix = '0;
        end else if (player.opaque) begin
            mix = player.color;
        end else if (obstacle.opaque) begin
            mix = obstacle.color;
        end else begin
            mix = BG_COLOR;
        end
    end

    // output register, syncs kept in step with colour
    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            rgb     <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
        end else if (pix_en) begin
            rgb     <= mix;
            hsync   <= raster.hsync;
            vsync   <= raster.vsync;
            blank_n <= raster.active;
        end
    end

endmodule

`default_nettype wire

// ==== logic/vga_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_game_top import vga_pkg::*; (
    input  wire                        sys_clk,
    input  wire                        reset,
    input  wire [$bits(pix565_t)-1:0]  ram_q,
    output ram_addr_t                  ram_addr,
    output logic                       vblank_start,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       blank_n,
    output logic                       pix_clk,
    output rgb_t                       rgb
);

    logic        pix_en;
    raster_t     raster;
    raster_t     raster_drawn;
    scene_pos_t  scene;

    rom_addr_t   player_addr;
    rom_addr_t   obstacle_addr;
    pix565_t     player_q;
    pix565_t     obstacle_q;
    sprite_pix_t player_pix;
    sprite_pix_t obstacle_pix;

    // strobe goes out as the pixel clock
    assign pix_clk = pix_en;

    vga_timing u_timing (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .pix_en       (pix_en),
        .raster       (raster),
        .vblank_start (vblank_start)
    );

    // positions refresh once per frame in vblank
    position_fetch u_fetch (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .vblank_start (vblank_start),
        .ram_q        (ram_q),
        .ram_addr     (ram_addr),
        .scene        (scene)
    );

    sprite_rom u_rom (
        .sys_clk (sys_clk),
        .pix_en  (pix_en),
        .addr_a  (player_addr),
        .addr_b  (obstacle_addr),
        .q_a     (player_q),
        .q_b     (obstacle_q)
    );

    sprite_draw #(.BASE(PLAYER_BASE)) u_player (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .pix_en     (pix_en),
        .raster     (raster),
        .pos        (scene.player),
        .rom_addr   (player_addr),
        .rom_q      (player_q),
        .pix        (player_pix),
        .raster_out (raster_drawn)
    );

    // same delayed raster as the player, left open
    sprite_draw #(.BASE(OBSTACLE_BASE)) u_obstacle (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .pix_en     (pix_en),
        .raster     (raster),
        .pos        (scene.obstacle),
        .rom_addr   (obstacle_addr),
        .rom_q      (obstacle_q),
        .pix        (obstacle_pix),
        .raster_out ()
    );

    pixel_mixer u_mixer (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .pix_en   (pix_en),
        .raster   (raster_drawn),
        .player   (player_pix),
        .obstacle (obstacle_pix),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank_n  (blank_n)
    );

endmodule

`default_nettype wire

// ==== test/vga_game_checks.svh ====
`ifndef VGA_GAME_CHECKS_SVH
`define VGA_GAME_CHECKS_SVH

// colour of one output pixel
task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
endtask

// single flag, syncs and blanking
task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("Error: %s expected %b actual %b", name, expected, actual));
    end
endtask

task automatic check_addr(input string name, input ram_addr_t expected, input ram_addr_t actual);
    if (actual !== expected) begin
        abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
endtask

// raster model, sync pulses right after the front porch
function automatic logic hsync_model(input int col);
    return !((col >= H_ACTIVE + H_FRONT) && (col < H_ACTIVE + H_FRONT + H_SYNC));
endfunction

function automatic logic vsync_model(input int row);
    return !((row >= V_ACTIVE + V_FRONT) && (row < V_ACTIVE + V_FRONT + V_SYNC));
endfunction

// image model, checker of 4x4 tiles, 2x2 keyed corners
function automatic pix565_t image_model(input bit obstacle, input int row, input int col);
    bit edge_r;
    bit edge_c;
    edge_r = (row < 2) || (row > SPRITE_SIZE - 3);
    edge_c = (col < 2) || (col > SPRITE_SIZE - 3);
    if (edge_r && edge_c) begin
        return KEY_COLOR;
    end
    if (((row / 4) + (col / 4)) % 2 == 1) begin
        return obstacle ? 16'h07E0 : 16'hFFE0;
    end
    return obstacle ? 16'h8410 : 16'h001F;
endfunction

// player first, then obstacle, then background
function automatic rgb_t pixel_model(input scene_pos_t s, input int h, input int v);
    sprite_pos_t p;
    pix565_t     w;
    for (int i = 0; i < 2; i++) begin
        p = (i == 0) ? s.player : s.obstacle;
        if (h >= p.x && h < p.x + SPRITE_SIZE && v >= p.y && v < p.y + SPRITE_SIZE) begin
            w = image_model(i == 1, v - p.y, h - p.x);
            // channels widened by repeating their top bits
            if (w != KEY_COLOR) begin
                return {w[15:11], w[15:13], w[10:5], w[10:9], w[4:0], w[4:2]};
            end
        end
    end
    return BG_COLOR;
endfunction

`endif

// ==== test/vga_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_game_tb import vga_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_CYCLES = 840000;
    localparam int NUM_FRAMES   = 4;
    localparam int MAX_PROBES   = 20;
    // six frames of sys_clk
    localparam int TIMEOUT_NS   = 6 * FRAME_CYCLES * CLK_PERIOD;

    logic        sys_clk;
    logic        reset;
    logic [15:0] ram_q;
    ram_addr_t   ram_addr;
    logic        vblank_start;
    logic        hsync;
    logic        vsync;
    logic        blank_n;
    logic        pix_clk;
    rgb_t        rgb;

    // frame table, position words plus probes and their colours
    logic [15:0] pos_words [NUM_FRAMES][4];
    int          probe_count [NUM_FRAMES];
    int          probe_h [NUM_FRAMES][MAX_PROBES];
    int          probe_v [NUM_FRAMES][MAX_PROBES];
    rgb_t        probe_rgb [NUM_FRAMES][MAX_PROBES];

    // own raster count, locked on the first sync edges
    int   cur_col;
    int   cur_line;
    int   out_frame;
    bit   h_locked;
    bit   v_locked;
    logic prev_hsync;
    logic prev_vsync;
    event pixel_seen;

    // bus side
    longint      cycle;
    longint      last_vblank;
    int          vb_count;
    int          load_frame;
    int          fetch_step;
    logic [15:0] ram_next;
    logic        pix_expect;
    logic [31:0] lcg_state;
    int          errors;
    bit          found;

    task automatic abort_run(input string reason);
        errors++;
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    `include "vga_game_checks.svh"

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_probe(input int f, input int h, input int v, output bit added);
        int key;
        int pos;
        key   = v * H_TOTAL + h;
        added = (h >= 0) && (h < H_ACTIVE) && (v >= 0) && (v < V_ACTIVE) &&
                (probe_count[f] < MAX_PROBES);
        for (int k = 0; k < probe_count[f]; k++) begin
            if (probe_v[f][k] * H_TOTAL + probe_h[f][k] == key) begin
                added = 1'b0;
            end
        end
        if (added) begin
            // sorted insert, probes go by in raster order
            pos = probe_count[f];
            while (pos > 0 && probe_v[f][pos - 1] * H_TOTAL + probe_h[f][pos - 1] > key) begin
                probe_h[f][pos] = probe_h[f][pos - 1];
                probe_v[f][pos] = probe_v[f][pos - 1];
                pos--;
            end
            probe_h[f][pos] = h;
            probe_v[f][pos] = v;
            probe_count[f]++;
        end
    endtask

    // words: player x, player y, obstacle x, obstacle y
    task automatic fill_frame(input int f, input logic [15:0] w0, input logic [15:0] w1,
                              input logic [15:0] w2, input logic [15:0] w3);
        scene_pos_t  s;
        sprite_pos_t p;
        bit          added;
        pos_words[f][0] = w0;
        pos_words[f][1] = w1;
        pos_words[f][2] = w2;
        pos_words[f][3] = w3;
        // upper bits of each word are ignored
        s = {w0[9:0], w1[9:0], w2[9:0], w3[9:0]};
        probe_count[f] = 0;
        for (int i = 0; i < 2; i++) begin
            p = (i == 0) ? s.player : s.obstacle;
            // keyed corners
            add_probe(f, p.x, p.y, added);
            add_probe(f, p.x + 31, p.y, added);
            add_probe(f, p.x, p.y + 31, added);
            add_probe(f, p.x + 31, p.y + 31, added);
            // random pixels in and just around the box
            for (int k = 0; k < 4; k++) begin
                added = 1'b0;
                while (!added) begin
                    lcg_state = lcg_next(lcg_state);
                    add_probe(f, int'(p.x) + int'(lcg_state[15:8] % 40) - 4,
                              int'(p.y) + int'(lcg_state[25:18] % 40) - 4, added);
                end
            end
        end
        for (int k = 0; k < probe_count[f]; k++) begin
            probe_rgb[f][k] = pixel_model(s, probe_h[f][k], probe_v[f][k]);
        end
    endtask

    vga_game_top u_dut (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .ram_q        (ram_q),
        .ram_addr     (ram_addr),
        .vblank_start (vblank_start),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank_n      (blank_n),
        .pix_clk      (pix_clk),
        .rgb          (rgb)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // ram read latency of one clock
    always @(posedge sys_clk) begin
        #2;
        ram_q = ram_next;
    end

    // vblank spacing, fetch address order, ram lookup
    always @(negedge sys_clk) begin
        cycle++;
        if (reset) begin
            // strobe on every second clock, high on the first one after reset
            check_bit("pix_clk", pix_expect, pix_clk);
            pix_expect = ~pix_expect;
            if (fetch_step > 0) begin
                // each word held for an issue and a capture clock
                check_addr("fetch address", POS_BASE + ram_addr_t'((fetch_step - 1) / 2), ram_addr);
                fetch_step = (fetch_step == 8) ? 0 : fetch_step + 1;
            end
            if (vblank_start) begin
                if (vb_count > 0 && cycle - last_vblank != FRAME_CYCLES) begin
                    abort_run("vblank_start did not pulse exactly once per frame");
                end
                last_vblank = cycle;
                load_frame  = vb_count % NUM_FRAMES;
                vb_count++;
                fetch_step  = 1;
            end
        end
        if (ram_addr >= POS_BASE && ram_addr < POS_BASE + 16'd4) begin
            ram_next = pos_words[load_frame][ram_addr - POS_BASE];
        end else begin
            ram_next = ram_addr ^ 16'hA5A5;
        end
    end

    // one sample per pixel, outputs settled mid-cycle
    always @(negedge sys_clk) begin
        if (reset && pix_clk) begin
            if (h_locked) begin
                cur_col = (cur_col == H_TOTAL - 1) ? 0 : cur_col + 1;
                if (cur_col == 0 && v_locked) begin
                    cur_line = (cur_line == V_TOTAL - 1) ? 0 : cur_line + 1;
                    if (cur_line == 0) begin
                        out_frame++;
                    end
                end
            end
            if (prev_hsync === 1'b1 && hsync === 1'b0 && !h_locked) begin
                h_locked = 1'b1;
                cur_col  = H_ACTIVE + H_FRONT;
            end
            if (prev_vsync === 1'b1 && vsync === 1'b0 && !v_locked) begin
                v_locked = 1'b1;
                cur_line = V_ACTIVE + V_FRONT;
            end
            if (h_locked && v_locked) begin
                check_bit("hsync", hsync_model(cur_col), hsync);
                check_bit("vsync", vsync_model(cur_line), vsync);
                check_bit("blank_n", (cur_col < H_ACTIVE) && (cur_line < V_ACTIVE), blank_n);
                if (!blank_n) begin
                    check_rgb("rgb in blanking", '0, rgb);
                end
                -> pixel_seen;
            end
            prev_hsync = hsync;
            prev_vsync = vsync;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout, not all probe pixels were seen");
    end

    initial begin
        sys_clk     = 1'b0;
        reset       = 1'b0;
        ram_q       = '0;
        ram_next    = '0;
        pix_expect  = 1'b1;
        cur_col     = 0;
        cur_line    = 0;
        out_frame   = 0;
        h_locked    = 1'b0;
        v_locked    = 1'b0;
        prev_hsync  = 1'b1;
        prev_vsync  = 1'b1;
        cycle       = 0;
        last_vblank = 0;
        vb_count    = 0;
        load_frame  = 0;
        fetch_step  = 0;
        errors      = 0;
        lcg_state   = 32'h6ed0;
        // apart, overlapping, at the edges, overlapping with junk upper bits
        fill_frame(0, 16'h0028, 16'h003C, 16'h012C, 16'h00C8);
        fill_frame(1, 16'hFC64, 16'h8064, 16'h005A, 16'h005A);
        fill_frame(2, 16'h0260, 16'h01C0, 16'h7C00, 16'h0400);
        fill_frame(3, 16'hA140, 16'hA0F0, 16'h0150, 16'h00FA);
        repeat (3) @(posedge sys_clk);
        #2;
        reset = 1'b1;
        // table entry f is fetched in vblank and shown in output frame f+1
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int k = 0; k < probe_count[f]; k++) begin
                found = 1'b0;
                while (!found) begin
                    @(pixel_seen);
                    if (out_frame > f + 1) begin
                        abort_run($sformatf("probe (%0d,%0d) of frame %0d never came",
                                            probe_h[f][k], probe_v[f][k], f));
                    end
                    found = (out_frame == f + 1) && (cur_col == probe_h[f][k]) &&
                            (cur_line == probe_v[f][k]);
                end
                check_rgb($sformatf("frame %0d pixel (%0d,%0d)", f, cur_col, cur_line),
                          probe_rgb[f][k], rgb);
            end
        end
        if (vb_count < NUM_FRAMES) begin
            abort_run("too few vblank_start pulses");
        end
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vga_game_top.f ====
+incdir+test
logic/vga_pkg.sv
logic/vga_timing.sv
logic/position_fetch.sv
logic/sprite_rom.sv
logic/sprite_draw.sv
logic/pixel_mixer.sv
logic/vga_game_top.sv
test/vga_game_tb.sv

// ==== Bender.yml ====
package:
  name: vga_game

sources:
  - logic/vga_pkg.sv
  - logic/vga_timing.sv
  - logic/position_fetch.sv
  - logic/sprite_rom.sv
  - logic/sprite_draw.sv
  - logic/pixel_mixer.sv
  - logic/vga_game_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/vga_game_tb.sv
